// File: src/control_sequencer.sv
`timescale 1ns/1ps

module control_sequencer (
        input  logic                             clk,
        input  logic                             arst_n,
        input  logic [mips_isa_pkg::INSTR_W-1:0] instr,
        input  logic                             mem_ready,
        input  ctrl_state_pkg::state_t           dispatch_state,
        output logic [mips_isa_pkg::INSTR_W-1:0] instr_reg,
        output logic                             instr_done,
        ctrl_if.seq                              ctl
);
        import ctrl_state_pkg::*;

        state_t state_q;
        state_t state_next;

        assign ctl.state = state_q;

        always_comb
        begin
                case (ctl.word.next_mode)
                NM_FETCH:     state_next = S_FETCH;
                NM_DISPATCH:  state_next = dispatch_state;
                NM_GOTO:      state_next = ctl.word.goto;
                NM_MEM_FETCH: state_next = mem_ready ? S_FETCH : state_q;       // Hold on wait
                NM_MEM_GOTO:  state_next = mem_ready ? ctl.word.goto : state_q;
                default:      state_next = S_FETCH;
                endcase
        end

        // Last state of an instruction, the one that returns to fetch
        always_comb
        begin
                case (ctl.word.next_mode)
                NM_FETCH:     instr_done = 1'b1;
                NM_MEM_FETCH: instr_done = mem_ready;
                default:      instr_done = 1'b0;
                endcase
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        state_q <= S_FETCH;
                end
                else
                begin
                        state_q <= state_next;
                end
        end

        // Instruction register, written on the fetch capture cycle
        always_ff @(posedge clk)
        begin
                if (ctl.word.ir_write)
                begin
                        instr_reg <= instr;
                end
        end

endmodule

// File: src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
        input  logic                              clk,
        input  logic                              arst_n,
        input  logic [mips_isa_pkg::INSTR_W-1:0]  instr,
        input  logic                              mem_ready,
        output logic                              mem_read,
        output logic                              mem_write,
        output logic                              ir_write,
        output logic                              pc_write,
        output logic                              pc_write_cond,
        output logic                              reg_write,
        output logic                              hilo_write,
        output logic                              link,
        output logic [mips_isa_pkg::ALU_OP_W-1:0] alu_op,
        output logic                              instr_done
);
        import mips_isa_pkg::*;
        import ctrl_state_pkg::*;

        logic [INSTR_W-1:0] instr_reg;
        state_t             dispatch_state;

        ctrl_if ctl (
                .mem_ready (mem_ready)
        );

        state_encoder u_encoder (
                .instr          (instr_reg),
                .dispatch_state (dispatch_state)
        );

        micro_rom u_rom (
                .ctl (ctl.rom)
        );

        control_sequencer u_seq (
                .clk            (clk),
                .arst_n         (arst_n),
                .instr          (instr),
                .mem_ready      (mem_ready),
                .dispatch_state (dispatch_state),
                .instr_reg      (instr_reg),
                .instr_done     (instr_done),
                .ctl            (ctl.seq)
        );

        // Datapath strobes straight from the control word
        assign mem_read      = ctl.word.mem_read;
        assign mem_write     = ctl.word.mem_write;
        assign ir_write      = ctl.word.ir_write;
        assign pc_write      = ctl.word.pc_write;
        assign pc_write_cond = ctl.word.pc_write_cond;
        assign reg_write     = ctl.word.reg_write;
        assign hilo_write    = ctl.word.hilo_write;
        assign link          = ctl.word.link;
        assign alu_op        = ctl.word.alu_op;

endmodule

// File: src/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if (
        input logic mem_ready
);
        import ctrl_state_pkg::*;

        state_t     state;      // Current microcode state
        ctrl_word_t word;       // Control word for that state

        modport seq (
                output state,
                input  word
        );

        // Table gates the fetch strobes with memory ready
        modport rom (
                input  state,
                input  mem_ready,
                output word
        );

endinterface

// File: src/ctrl_state_pkg.sv
package ctrl_state_pkg;

        localparam int STATE_W = 7;

        typedef logic [STATE_W-1:0] state_t;

        // Fixed states of the sequencer
        localparam state_t S_FETCH   = 7'd0;
        localparam state_t S_SKIP    = 7'd1;
        localparam state_t S_DECODE  = 7'd2;
        localparam state_t S_ALU_WB  = 7'd8;
        localparam state_t S_LOAD_WB = 7'd14;

        // Execute states, numbered as the encoder emits them
        localparam state_t S_ADDU  = 7'd6;
        localparam state_t S_STORE = 7'd7;     // SB, SH and SW
        localparam state_t S_BEQ   = 7'd11;
        localparam state_t S_LOAD  = 7'd13;    // Every load width
        localparam state_t S_SUBU  = 7'd17;
        localparam state_t S_ADDIU = 7'd18;
        localparam state_t S_SLTU  = 7'd19;
        localparam state_t S_SLTIU = 7'd20;
        localparam state_t S_CLO   = 7'd21;
        localparam state_t S_CLZ   = 7'd22;
        localparam state_t S_AND   = 7'd23;
        localparam state_t S_ANDI  = 7'd24;
        localparam state_t S_OR    = 7'd25;
        localparam state_t S_ORI   = 7'd26;
        localparam state_t S_XOR   = 7'd27;
        localparam state_t S_XORI  = 7'd28;
        localparam state_t S_NOR   = 7'd29;
        localparam state_t S_LUI   = 7'd30;
        localparam state_t S_SLL   = 7'd31;
        localparam state_t S_SRA   = 7'd32;
        localparam state_t S_SRL   = 7'd33;
        localparam state_t S_MOVN  = 7'd34;
        localparam state_t S_MOVZ  = 7'd35;
        localparam state_t S_BGEZ  = 7'd37;
        localparam state_t S_BGTZ  = 7'd39;
        localparam state_t S_BNE   = 7'd41;
        localparam state_t S_BLEZ  = 7'd42;
        localparam state_t S_JR    = 7'd44;
        localparam state_t S_MFHI  = 7'd45;
        localparam state_t S_MFLO  = 7'd46;
        localparam state_t S_MTHI  = 7'd47;
        localparam state_t S_MTLO  = 7'd48;
        localparam state_t S_MULTU = 7'd49;
        localparam state_t S_SD    = 7'd50;
        localparam state_t S_BAL   = 7'd56;

        typedef enum logic [2:0] {
                NM_FETCH     = 3'd0,    // Back to fetch
                NM_DISPATCH  = 3'd1,    // Take the encoder state
                NM_GOTO      = 3'd2,    // Take the goto field
                NM_MEM_FETCH = 3'd3,    // Wait for memory, then fetch
                NM_MEM_GOTO  = 3'd4     // Wait for memory, then goto
        } next_mode_e;

        typedef struct packed {
                logic                  mem_read;
                logic                  mem_write;
                logic                  ir_write;
                logic                  pc_write;
                logic                  pc_write_cond;
                logic                  reg_write;
                logic                  hilo_write;
                logic                  link;
                mips_isa_pkg::alu_op_e alu_op;
                next_mode_e            next_mode;
                state_t                goto;
        } ctrl_word_t;

endpackage

// File: src/micro_rom.sv
`timescale 1ns/1ps

module micro_rom (
        ctrl_if.rom ctl
);
        import mips_isa_pkg::*;
        import ctrl_state_pkg::*;

        ctrl_word_t w;

        assign ctl.word = w;

        always_comb
        begin
                w = '{alu_op: ALU_ADD, next_mode: NM_FETCH, goto: S_FETCH, default: 1'b0};

                case (ctl.state)
                S_FETCH:
                begin
                        w.mem_read  = 1'b1;
                        w.ir_write  = ctl.mem_ready;    // Only on the capture cycle
                        w.pc_write  = ctl.mem_ready;    // PC + 4
                        w.next_mode = NM_MEM_GOTO;
                        w.goto      = S_DECODE;
                end
                S_DECODE:
                        w.next_mode = NM_DISPATCH;      // ALU forms branch target here
                S_ADDU, S_SUBU, S_ADDIU, S_SLTU, S_SLTIU, S_CLO, S_CLZ,
                S_AND, S_ANDI, S_OR, S_ORI, S_XOR, S_XORI, S_NOR, S_LUI,
                S_SLL, S_SRA, S_SRL, S_MOVN, S_MOVZ, S_MFHI, S_MFLO:
                begin
                        w.next_mode = NM_GOTO;
                        w.goto      = S_ALU_WB;
                end
                S_ALU_WB, S_LOAD_WB:
                        w.reg_write = 1'b1;
                S_MTHI, S_MTLO, S_MULTU:
                        w.hilo_write = 1'b1;            // No GPR write-back
                S_STORE, S_SD:
                begin
                        w.mem_write = 1'b1;
                        w.next_mode = NM_MEM_FETCH;
                end
                S_LOAD:
                begin
                        w.mem_read  = 1'b1;
                        w.next_mode = NM_MEM_GOTO;
                        w.goto      = S_LOAD_WB;
                end
                S_BEQ, S_BGEZ, S_BGTZ, S_BNE, S_BLEZ:
                        w.pc_write_cond = 1'b1;         // Datapath decides taken
                S_JR:
                        w.pc_write = 1'b1;
                S_BAL:
                begin
                        w.pc_write_cond = 1'b1;
                        w.reg_write     = 1'b1;
                        w.link          = 1'b1;         // Return address to r31
                end
                default:
                        w.next_mode = NM_FETCH;         // Skip and unused states
                endcase

                // ALU operation per execute state
                case (ctl.state)
                S_SUBU:          w.alu_op = ALU_SUB;
                S_SLTU, S_SLTIU: w.alu_op = ALU_SLTU;
                S_CLO:           w.alu_op = ALU_CLO;
                S_CLZ:           w.alu_op = ALU_CLZ;
                S_AND, S_ANDI:   w.alu_op = ALU_AND;
                S_OR, S_ORI:     w.alu_op = ALU_OR;
                S_XOR, S_XORI:   w.alu_op = ALU_XOR;
                S_NOR:           w.alu_op = ALU_NOR;
                S_LUI:           w.alu_op = ALU_LUI;
                S_SLL:           w.alu_op = ALU_SLL;
                S_SRA:           w.alu_op = ALU_SRA;
                S_SRL:           w.alu_op = ALU_SRL;
                S_MOVN:          w.alu_op = ALU_MOVN;
                S_MOVZ:          w.alu_op = ALU_MOVZ;
                S_MULTU:         w.alu_op = ALU_MULTU;
                S_MFHI:          w.alu_op = ALU_MFHI;
                S_MFLO:          w.alu_op = ALU_MFLO;
                S_MTHI:          w.alu_op = ALU_MTHI;
                S_MTLO:          w.alu_op = ALU_MTLO;
                default:         w.alu_op = ALU_ADD;    // Fetch, address, branch
                endcase
        end

endmodule

// File: src/mips_isa_pkg.sv
package mips_isa_pkg;

        localparam int INSTR_W  = 32;
        localparam int OPCODE_W = 6;
        localparam int REG_W    = 5;    // rs, rt and rd
        localparam int SHAMT_W  = 5;
        localparam int FUNCT_W  = 6;
        localparam int ALU_OP_W = 5;

        // One code per ALU operation of the subset
        typedef enum logic [ALU_OP_W-1:0] {
                ALU_ADD   = 5'd0,       // Also used for address and PC math
                ALU_SUB   = 5'd1,
                ALU_SLTU  = 5'd2,
                ALU_AND   = 5'd3,
                ALU_OR    = 5'd4,
                ALU_XOR   = 5'd5,
                ALU_NOR   = 5'd6,
                ALU_LUI   = 5'd7,
                ALU_SLL   = 5'd8,
                ALU_SRL   = 5'd9,
                ALU_SRA   = 5'd10,
                ALU_CLO   = 5'd11,
                ALU_CLZ   = 5'd12,
                ALU_MOVN  = 5'd13,
                ALU_MOVZ  = 5'd14,
                ALU_MULTU = 5'd15,
                ALU_MFHI  = 5'd16,
                ALU_MFLO  = 5'd17,
                ALU_MTHI  = 5'd18,
                ALU_MTLO  = 5'd19
        } alu_op_e;

endpackage

// File: src/state_encoder.sv
`timescale 1ns/1ps

module state_encoder (
        input  logic [mips_isa_pkg::INSTR_W-1:0] instr,
        output ctrl_state_pkg::state_t           dispatch_state
);
        import mips_isa_pkg::*;
        import ctrl_state_pkg::*;

        logic [OPCODE_W-1:0] opcode;
        logic [REG_W-1:0]    rt;
        logic [REG_W-1:0]    rd;
        logic [SHAMT_W-1:0]  shamt;
        logic [FUNCT_W-1:0]  funct;

        // rs never takes part in the decode
        assign opcode = instr[31:26];
        assign rt     = instr[20:16];
        assign rd     = instr[15:11];
        assign shamt  = instr[10:6];
        assign funct  = instr[5:0];

        always_comb
        begin
                casez ({opcode, rt, rd, shamt, funct})
                // Arithmetic and logic
                27'b000000_?????_?????_?????_100001: dispatch_state = S_ADDU;   // ADDU
                27'b000000_?????_?????_?????_100011: dispatch_state = S_SUBU;   // SUBU
                27'b001001_?????_?????_?????_??????: dispatch_state = S_ADDIU;  // ADDIU
                27'b000000_?????_00000_00000_011001: dispatch_state = S_MULTU;  // MULTU
                27'b000000_?????_?????_?????_101011: dispatch_state = S_SLTU;   // SLTU
                27'b001011_?????_?????_?????_??????: dispatch_state = S_SLTIU;  // SLTIU
                27'b011100_?????_?????_?????_100001: dispatch_state = S_CLO;    // CLO
                27'b011100_?????_?????_?????_100000: dispatch_state = S_CLZ;    // CLZ
                27'b000000_?????_?????_?????_100100: dispatch_state = S_AND;    // AND
                27'b001100_?????_?????_?????_??????: dispatch_state = S_ANDI;   // ANDI
                27'b000000_?????_?????_?????_100101: dispatch_state = S_OR;     // OR
                27'b001101_?????_?????_?????_??????: dispatch_state = S_ORI;    // ORI
                27'b000000_?????_?????_?????_100110: dispatch_state = S_XOR;    // XOR
                27'b001110_?????_?????_?????_??????: dispatch_state = S_XORI;   // XORI
                27'b000000_?????_?????_?????_100111: dispatch_state = S_NOR;    // NOR
                27'b001111_?????_?????_?????_??????: dispatch_state = S_LUI;    // LUI
                27'b000000_?????_?????_?????_000000: dispatch_state = S_SLL;    // SLL and NOP
                27'b000000_?????_?????_?????_000011: dispatch_state = S_SRA;    // SRA
                27'b000000_?????_?????_?????_000010: dispatch_state = S_SRL;    // SRL
                27'b000000_?????_?????_?????_001011: dispatch_state = S_MOVN;   // MOVN
                27'b000000_?????_?????_?????_001010: dispatch_state = S_MOVZ;   // MOVZ
                27'b000000_?????_?????_?????_010000: dispatch_state = S_MFHI;   // MFHI
                27'b000000_?????_?????_?????_010010: dispatch_state = S_MFLO;   // MFLO
                27'b000000_?????_?????_?????_010001: dispatch_state = S_MTHI;   // MTHI
                27'b000000_?????_?????_?????_010011: dispatch_state = S_MTLO;   // MTLO

                // Stores, narrow widths share one state
                27'b101000_?????_?????_?????_??????,
                27'b101001_?????_?????_?????_??????,
                27'b101011_?????_?????_?????_??????: dispatch_state = S_STORE;  // SB, SH, SW
                27'b111111_?????_?????_?????_??????: dispatch_state = S_SD;     // SD

                // Branches and jumps
                27'b000100_?????_?????_?????_??????: dispatch_state = S_BEQ;    // BEQ and B
                27'b000001_00001_?????_?????_??????: dispatch_state = S_BGEZ;   // BGEZ
                27'b000111_00000_?????_?????_??????: dispatch_state = S_BGTZ;   // BGTZ
                27'b000110_00000_?????_?????_??????: dispatch_state = S_BLEZ;   // BLEZ
                27'b000001_10001_?????_?????_??????: dispatch_state = S_BAL;    // BAL
                27'b000101_?????_?????_?????_??????: dispatch_state = S_BNE;    // BNE
                27'b000000_00000_00000_?????_001000: dispatch_state = S_JR;     // JR

                // Loads of every width, LL treated as LW
                27'b100011_?????_?????_?????_??????,
                27'b110000_?????_?????_?????_??????,
                27'b100001_?????_?????_?????_??????,
                27'b100101_?????_?????_?????_??????,
                27'b100000_?????_?????_?????_??????,
                27'b100100_?????_?????_?????_??????: dispatch_state = S_LOAD;

                default: dispatch_state = S_SKIP;                               // Unknown word
                endcase
        end

endmodule

// File: verification/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;
        import mips_isa_pkg::*;

        typedef struct packed {
                logic [31:0] word;
                logic [3:0]  cycles;    // States after decode without memory waits
                logic [1:0]  reg_w;
                logic [1:0]  mem_w;     // Accepted writes only
                logic [1:0]  hilo_w;
                logic [1:0]  pcc;
                logic [1:0]  lnk;
                logic [1:0]  pcw;
                logic [4:0]  alu;       // In the first execute cycle
        } row_t;

        logic        clk = 1'b0;
        logic        arst_n;
        logic [31:0] instr;
        logic        mem_ready;
        logic        mem_read;
        logic        mem_write;
        logic        ir_write;
        logic        pc_write;
        logic        pc_write_cond;
        logic        reg_write;
        logic        hilo_write;
        logic        link;
        logic [4:0]  alu_op;
        logic        instr_done;

        row_t        rows [$];
        logic [31:0] next_instr;
        int          wait_left;         // Memory latency left on this access
        logic        rd_pending;
        logic        wr_pending;

        control_unit uut (.*);

        always #50 clk = ~clk;

        task automatic report_mismatch(input string what, input int got, input int exp);
                $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
                $display("Test FAILED");
                $fatal(1, "wrong value");
        endtask

        task automatic report_timeout(input string what);
                $display("Timed out at %0t while %s", $time, what);
                $display("Test FAILED");
                $fatal(1, "timeout");
        endtask

        // Drive after the edge and sample mid cycle
        task automatic step_cycle();
                @(posedge clk);
                #5;
                instr = next_instr;
                if (mem_read || mem_write)
                begin
                        mem_ready = (wait_left == 0);
                        wait_left = (wait_left == 0) ? $urandom % 4 : wait_left - 1;
                end
                else
                begin
                        mem_ready = $urandom % 2;       // Ignored outside memory states
                end
                #40;
                assert (!ir_write || (mem_ready && mem_read))
                else report_mismatch("ir_write without fetch capture", ir_write, 0);
                assert (!rd_pending || mem_read)
                else report_mismatch("held mem_read", mem_read, 1);
                assert (!wr_pending || mem_write)
                else report_mismatch("held mem_write", mem_write, 1);
                rd_pending = mem_read && !mem_ready;
                wr_pending = mem_write && !mem_ready;
        endtask

        task automatic run_row(input row_t r);
                int   n;
                int   cycles;
                int   reg_c;
                int   mem_c;
                int   hilo_c;
                int   pcc_c;
                int   link_c;
                int   pcw_c;
                logic fetched;
                logic done;

                next_instr = r.word;
                fetched = 1'b0;
                for (n = 0; n < 12 && !fetched; n++)
                begin
                        step_cycle();
                        assert (mem_read && !instr_done)
                        else report_mismatch("fetch mem_read", mem_read, 1);
                        assert (ir_write == mem_ready)
                        else report_mismatch("fetch ir_write", ir_write, mem_ready);
                        assert (pc_write == mem_ready)
                        else report_mismatch("fetch pc_write", pc_write, mem_ready);
                        assert ({mem_write, pc_write_cond, reg_write, hilo_write, link} == 5'd0)
                        else report_mismatch("fetch strobes", 1, 0);
                        assert (alu_op == ALU_ADD)
                        else report_mismatch("fetch alu_op", alu_op, ALU_ADD);
                        fetched = ir_write;
                end
                if (!fetched)
                        report_timeout("waiting for the instruction fetch to capture");

                step_cycle();   // Decode
                assert ({mem_read, mem_write, ir_write, pc_write, pc_write_cond, reg_write,
                         hilo_write, link, instr_done} == 9'd0)
                else report_mismatch("decode strobes", 1, 0);

                cycles = 0;
                reg_c  = 0;
                mem_c  = 0;
                hilo_c = 0;
                pcc_c  = 0;
                link_c = 0;
                pcw_c  = 0;
                done   = 1'b0;
                for (n = 0; n < 20 && !done; n++)
                begin
                        step_cycle();
                        if (n == 0)
                        begin
                                assert (alu_op == r.alu)
                                else report_mismatch("alu_op", alu_op, r.alu);
                        end
                        assert (!ir_write) else report_mismatch("ir_write in execute", ir_write, 0);
                        if (!((mem_read || mem_write) && !mem_ready))
                                cycles++;
                        reg_c  += reg_write;
                        mem_c  += mem_write && mem_ready;
                        hilo_c += hilo_write;
                        pcc_c  += pc_write_cond;
                        link_c += link;
                        pcw_c  += pc_write;
                        done    = instr_done;
                end
                if (!done)
                        report_timeout("waiting for instr_done");

                assert (cycles == r.cycles)
                else report_mismatch("cycles after decode", cycles, r.cycles);
                assert (reg_c == r.reg_w)
                else report_mismatch("reg_write count", reg_c, r.reg_w);
                assert (mem_c == r.mem_w)
                else report_mismatch("mem_write count", mem_c, r.mem_w);
                assert (hilo_c == r.hilo_w)
                else report_mismatch("hilo_write count", hilo_c, r.hilo_w);
                assert (pcc_c == r.pcc)
                else report_mismatch("pc_write_cond count", pcc_c, r.pcc);
                assert (link_c == r.lnk)
                else report_mismatch("link count", link_c, r.lnk);
                assert (pcw_c == r.pcw)
                else report_mismatch("pc_write count", pcw_c, r.pcw);
        endtask

        initial
        begin
                arst_n     = 1'b0;
                instr      = '0;
                mem_ready  = 1'b0;
                next_instr = '0;
                rd_pending = 1'b0;
                wr_pending = 1'b0;
                void'($urandom(32'hb934));
                wait_left  = $urandom % 4;

                // word, cycles, reg, mem, hilo, pc_cond, link, pc, alu_op
                rows.push_back('{32'h00851021, 2, 1, 0, 0, 0, 0, 0, ALU_ADD});   // ADDU
                rows.push_back('{32'h00851023, 2, 1, 0, 0, 0, 0, 0, ALU_SUB});   // SUBU
                rows.push_back('{32'h34A200FF, 2, 1, 0, 0, 0, 0, 0, ALU_OR});    // ORI
                rows.push_back('{32'h00051080, 2, 1, 0, 0, 0, 0, 0, ALU_SLL});   // SLL
                rows.push_back('{32'h3C021234, 2, 1, 0, 0, 0, 0, 0, ALU_LUI});   // LUI
                rows.push_back('{32'h00001010, 2, 1, 0, 0, 0, 0, 0, ALU_MFHI});  // MFHI
                rows.push_back('{32'h00850019, 1, 0, 0, 1, 0, 0, 0, ALU_MULTU}); // MULTU
                rows.push_back('{32'h00800011, 1, 0, 0, 1, 0, 0, 0, ALU_MTHI});  // MTHI
                rows.push_back('{32'h00800013, 1, 0, 0, 1, 0, 0, 0, ALU_MTLO});  // MTLO
                rows.push_back('{32'h8C820008, 2, 1, 0, 0, 0, 0, 0, ALU_ADD});   // LW
                rows.push_back('{32'h80820008, 2, 1, 0, 0, 0, 0, 0, ALU_ADD});   // LB
                rows.push_back('{32'hAC820008, 1, 0, 1, 0, 0, 0, 0, ALU_ADD});   // SW
                rows.push_back('{32'hFC820008, 1, 0, 1, 0, 0, 0, 0, ALU_ADD});   // SD
                rows.push_back('{32'h10850004, 1, 0, 0, 0, 1, 0, 0, ALU_ADD});   // BEQ
                rows.push_back('{32'h04810004, 1, 0, 0, 0, 1, 0, 0, ALU_ADD});   // BGEZ
                rows.push_back('{32'h04110004, 1, 1, 0, 0, 1, 1, 0, ALU_ADD});   // BAL
                rows.push_back('{32'h03E00008, 1, 0, 0, 0, 0, 0, 1, ALU_ADD});   // JR
                rows.push_back('{32'h48000000, 1, 0, 0, 0, 0, 0, 0, ALU_ADD});   // Unknown

                #20;
                assert (mem_read && {mem_write, ir_write, pc_write, pc_write_cond, reg_write,
                                     hilo_write, link, instr_done} == 8'd0)
                else report_mismatch("strobes in reset", mem_read, 1);
                repeat (3) @(posedge clk);
                #5;
                arst_n = 1'b1;

                foreach (rows[i])
                        run_row(rows[i]);

                $display("Test OK");
                $finish;
        end

endmodule

// File: vlog.f
src/mips_isa_pkg.sv
src/ctrl_state_pkg.sv
src/ctrl_if.sv
src/state_encoder.sv
src/micro_rom.sv
src/control_sequencer.sv
src/control_unit.sv
verification/tb_control_unit.sv
